//--- verilog/memPkg.sv
package memPkg;

    //////////////////////////////////////////////////
    // Word widths
    //////////////////////////////////////////////////

    // CPU data and address word
    localparam int wordWidth = 16;

    // Address pins on the SRAM chips
    localparam int sramAddrWidth = 18;

    // Returned on a fetch that loses to a data access
    localparam logic [wordWidth-1:0] nopInstr = 16'h0800;

    //////////////////////////////////////////////////
    // Serial port addresses
    //////////////////////////////////////////////////

    localparam logic [wordWidth-1:0] com1Data    = 16'hBF00;
    localparam logic [wordWidth-1:0] com1Command = 16'hBF01;
    localparam logic [wordWidth-1:0] com2Data    = 16'hBF02;
    localparam logic [wordWidth-1:0] com2Command = 16'hBF03;

    // Target of the current data request
    typedef enum logic [1:0] {
        regionNone,
        regionRam1,
        regionUart,
        regionRam2
    } memRegion;

    // Sequencer state
    typedef enum logic [1:0] {
        phaseSetup,
        phaseCapture,
        phaseUartWait
    } memPhase;

endpackage

//--- verilog/sramPort.sv
`timescale 1ns/1ps

module sramPort (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,
    input  logic                             write,
    input  logic                             select,
    input  logic [memPkg::wordWidth-1:0]     addr,
    input  logic [memPkg::wordWidth-1:0]     wdata,
    output logic [memPkg::wordWidth-1:0]     rdata,
    inout  wire  [memPkg::wordWidth-1:0]     SramData,
    output logic [memPkg::sramAddrWidth-1:0] SramAddr,
    output logic                             SramEN,
    output logic                             SramOE,
    output logic                             SramWE
);

    localparam int padWidth = memPkg::sramAddrWidth - memPkg::wordWidth;

    logic                         active;
    logic                         driveBus;
    logic [memPkg::wordWidth-1:0] addrReg;
    logic [memPkg::wordWidth-1:0] wdataReg;

    // Top address bits always zero on this board
    assign SramAddr = {{padWidth{1'b0}}, addrReg};

    // Bus released unless a write is on the pins
    assign SramData = driveBus ? wdataReg : {memPkg::wordWidth{1'bz}};

    //////////////////////////////////////////////////
    // One strobe cycle per access
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            active   <= 1'b0;
            driveBus <= 1'b0;
            SramEN   <= 1'b1;
            SramOE   <= 1'b1;
            SramWE   <= 1'b1;
        end else if (start) begin
            active   <= 1'b1;
            driveBus <= write;
            // Chip stays disabled when only the bus is wanted
            SramEN   <= !select;
            SramOE   <= !(select && !write);
            SramWE   <= !(select && write);
        end else begin
            active   <= 1'b0;
            driveBus <= 1'b0;
            SramEN   <= 1'b1;
            SramOE   <= 1'b1;
            SramWE   <= 1'b1;
        end
    end

    // Address and data held through the access
    always_ff @(posedge clk) begin
        if (start) begin
            addrReg  <= addr;
            wdataReg <= wdata;
        end
    end

    // Sample the bus as the strobes rise
    always_ff @(posedge clk) begin
        if (active) begin
            rdata <= SramData;
        end
    end

endmodule

//--- verilog/uartBridge.sv
`timescale 1ns/1ps

module uartBridge (
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  logic       write,
    input  logic [7:0] busData,
    input  logic       data_ready,
    input  logic       tbre,
    input  logic       tsre,
    output logic       rdn,
    output logic       wrn,
    output logic [7:0] rxByte,
    output logic       done
);

    typedef enum logic [2:0] {
        stIdle,
        stWrStrobe,
        stWaitTbre,
        stWaitTsre,
        stRdWait,
        stRdCapture
    } uartState;

    uartState state;

    //////////////////////////////////////////////////
    // Serial handshake FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            state <= stIdle;
            rdn   <= 1'b1;
            wrn   <= 1'b1;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                stIdle: begin
                    if (start && write) begin
                        wrn   <= 1'b0;
                        state <= stWrStrobe;
                    end else if (start) begin
                        rdn   <= 1'b0;
                        state <= stRdWait;
                    end
                end
                // Byte is on the bus for this one cycle
                stWrStrobe: begin
                    wrn   <= 1'b1;
                    state <= stWaitTbre;
                end
                stWaitTbre: begin
                    if (tbre) begin
                        state <= stWaitTsre;
                    end
                end
                // Shift register empty means the byte has left
                stWaitTsre: begin
                    if (tsre) begin
                        done  <= 1'b1;
                        state <= stIdle;
                    end
                end
                stRdWait: begin
                    if (data_ready) begin
                        state <= stRdCapture;
                    end
                end
                stRdCapture: begin
                    rdn   <= 1'b1;
                    done  <= 1'b1;
                    state <= stIdle;
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // Received byte is still on the bus while rdn is low
    always_ff @(posedge clk) begin
        if (state == stRdCapture) begin
            rxByte <= busData;
        end
    end

endmodule

//--- verilog/memoryModule.sv
`timescale 1ns/1ps

module memoryModule #(
    parameter logic [memPkg::wordWidth-1:0] ram1Upper = 16'h8000
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [memPkg::wordWidth-1:0] pc,
    input  logic [memPkg::wordWidth-1:0] Address,
    input  logic [memPkg::wordWidth-1:0] WriteData,
    input  logic                         MemRead,
    input  logic                         MemWrite,
    output logic [memPkg::wordWidth-1:0] ReadData,
    output logic [memPkg::wordWidth-1:0] Instruct,
    output logic                         MemConflict,
    output logic                         noStop,
    output logic                         ram1Start,
    output logic                         ram1Write,
    output logic                         ram1Select,
    output logic [memPkg::wordWidth-1:0] ram1Addr,
    output logic [memPkg::wordWidth-1:0] ram1Wdata,
    input  logic [memPkg::wordWidth-1:0] ram1Rdata,
    output logic                         ram2Start,
    output logic                         ram2Write,
    output logic [memPkg::wordWidth-1:0] ram2Addr,
    output logic [memPkg::wordWidth-1:0] ram2Wdata,
    input  logic [memPkg::wordWidth-1:0] ram2Rdata,
    output logic                         uartStart,
    output logic                         uartWrite,
    input  logic [7:0]                   uartRxByte,
    input  logic                         uartDone
);

    memPkg::memRegion region;
    memPkg::memPhase  phase;
    memPkg::memRegion lastRead;
    logic             setupNow;
    logic             isUart;
    logic             lastFetch;
    logic             lastConflict;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    always_comb begin
        region = memPkg::regionNone;
        if (MemRead || MemWrite) begin
            if (Address < ram1Upper) begin
                region = memPkg::regionRam1;
            end else if (Address == memPkg::com1Data || Address == memPkg::com1Command ||
                         Address == memPkg::com2Data || Address == memPkg::com2Command) begin
                region = memPkg::regionUart;
            end else begin
                region = memPkg::regionRam2;
            end
        end
    end

    // UART shares the RAM 1 bus, so it blocks the fetch as well
    assign isUart      = (region == memPkg::regionUart);
    assign MemConflict = (region == memPkg::regionRam1) || isUart;
    assign setupNow    = (phase == memPkg::phaseSetup);

    // Stall only while the serial side is busy
    assign noStop = (phase != memPkg::phaseUartWait) || uartDone;

    //////////////////////////////////////////////////
    // Access requests
    //////////////////////////////////////////////////

    // RAM 1 carries the fetch, a data access or the UART write byte
    assign ram1Start  = setupNow && !(isUart && !MemWrite);
    assign ram1Write  = MemConflict && MemWrite;
    assign ram1Select = !isUart;
    assign ram1Addr   = MemConflict ? Address : pc;
    assign ram1Wdata  = WriteData;

    assign ram2Start = setupNow && (region == memPkg::regionRam2);
    assign ram2Write = MemWrite;
    assign ram2Addr  = Address;
    assign ram2Wdata = WriteData;

    assign uartStart = setupNow && isUart;
    assign uartWrite = MemWrite;

    //////////////////////////////////////////////////
    // Phase sequencer
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase <= memPkg::phaseSetup;
        end else begin
            case (phase)
                memPkg::phaseSetup: begin
                    if (isUart) begin
                        phase <= memPkg::phaseUartWait;
                    end else begin
                        phase <= memPkg::phaseCapture;
                    end
                end
                memPkg::phaseCapture: begin
                    phase <= memPkg::phaseSetup;
                end
                // Finish with a normal capture phase so the CPU can advance
                memPkg::phaseUartWait: begin
                    if (uartDone) begin
                        phase <= memPkg::phaseCapture;
                    end
                end
                default: begin
                    phase <= memPkg::phaseSetup;
                end
            endcase
        end
    end

    // Remember what the last setup phase launched
    always_ff @(posedge clk) begin
        if (!rst) begin
            lastFetch    <= 1'b0;
            lastConflict <= 1'b0;
            lastRead     <= memPkg::regionNone;
        end else if (setupNow) begin
            lastFetch    <= !MemConflict;
            lastConflict <= MemConflict;
            if (MemRead && !MemWrite) begin
                lastRead <= region;
            end else begin
                lastRead <= memPkg::regionNone;
            end
        end
    end

    //////////////////////////////////////////////////
    // Result registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            Instruct <= '0;
            ReadData <= '0;
        end else if (setupNow) begin
            // Port rdata was latched on the previous edge
            if (lastFetch) begin
                Instruct <= ram1Rdata;
            end else if (lastConflict) begin
                Instruct <= memPkg::nopInstr;
            end
            case (lastRead)
                memPkg::regionRam1: ReadData <= ram1Rdata;
                memPkg::regionRam2: ReadData <= ram2Rdata;
                default: ReadData <= ReadData;
            endcase
        end else if (uartDone && lastRead == memPkg::regionUart) begin
            ReadData <= {{(memPkg::wordWidth - 8){1'b0}}, uartRxByte};
        end
    end

endmodule

//--- verilog/memTop.sv
`timescale 1ns/1ps

module memTop #(
    parameter logic [memPkg::wordWidth-1:0] ram1Upper = 16'h8000
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [memPkg::wordWidth-1:0]     pc,
    input  logic [memPkg::wordWidth-1:0]     Address,
    input  logic [memPkg::wordWidth-1:0]     WriteData,
    input  logic                             MemRead,
    input  logic                             MemWrite,
    output logic [memPkg::wordWidth-1:0]     ReadData,
    output logic [memPkg::wordWidth-1:0]     Instruct,
    output logic                             MemConflict,
    output logic                             noStop,
    inout  wire  [memPkg::wordWidth-1:0]     Ram1Data,
    output logic [memPkg::sramAddrWidth-1:0] Ram1Addr,
    output logic                             Ram1EN,
    output logic                             Ram1OE,
    output logic                             Ram1WE,
    inout  wire  [memPkg::wordWidth-1:0]     Ram2Data,
    output logic [memPkg::sramAddrWidth-1:0] Ram2Addr,
    output logic                             Ram2EN,
    output logic                             Ram2OE,
    output logic                             Ram2WE,
    output logic                             rdn,
    output logic                             wrn,
    input  logic                             data_ready,
    input  logic                             tbre,
    input  logic                             tsre
);

    logic                         ram1Start;
    logic                         ram1Write;
    logic                         ram1Select;
    logic [memPkg::wordWidth-1:0] ram1Addr;
    logic [memPkg::wordWidth-1:0] ram1Wdata;
    logic [memPkg::wordWidth-1:0] ram1Rdata;
    logic                         ram2Start;
    logic                         ram2Write;
    logic [memPkg::wordWidth-1:0] ram2Addr;
    logic [memPkg::wordWidth-1:0] ram2Wdata;
    logic [memPkg::wordWidth-1:0] ram2Rdata;
    logic                         uartStart;
    logic                         uartWrite;
    logic [7:0]                   uartRxByte;
    logic                         uartDone;

    memoryModule #(
        .ram1Upper(ram1Upper)
    ) u_core (
        .clk        (clk),
        .rst        (rst),
        .pc         (pc),
        .Address    (Address),
        .WriteData  (WriteData),
        .MemRead    (MemRead),
        .MemWrite   (MemWrite),
        .ReadData   (ReadData),
        .Instruct   (Instruct),
        .MemConflict(MemConflict),
        .noStop     (noStop),
        .ram1Start  (ram1Start),
        .ram1Write  (ram1Write),
        .ram1Select (ram1Select),
        .ram1Addr   (ram1Addr),
        .ram1Wdata  (ram1Wdata),
        .ram1Rdata  (ram1Rdata),
        .ram2Start  (ram2Start),
        .ram2Write  (ram2Write),
        .ram2Addr   (ram2Addr),
        .ram2Wdata  (ram2Wdata),
        .ram2Rdata  (ram2Rdata),
        .uartStart  (uartStart),
        .uartWrite  (uartWrite),
        .uartRxByte (uartRxByte),
        .uartDone   (uartDone)
    );

    // Program and low data memory
    sramPort u_ram1 (
        .clk     (clk),
        .rst     (rst),
        .start   (ram1Start),
        .write   (ram1Write),
        .select  (ram1Select),
        .addr    (ram1Addr),
        .wdata   (ram1Wdata),
        .rdata   (ram1Rdata),
        .SramData(Ram1Data),
        .SramAddr(Ram1Addr),
        .SramEN  (Ram1EN),
        .SramOE  (Ram1OE),
        .SramWE  (Ram1WE)
    );

    // RAM 2 is enabled whenever it is started
    sramPort u_ram2 (
        .clk     (clk),
        .rst     (rst),
        .start   (ram2Start),
        .write   (ram2Write),
        .select  (1'b1),
        .addr    (ram2Addr),
        .wdata   (ram2Wdata),
        .rdata   (ram2Rdata),
        .SramData(Ram2Data),
        .SramAddr(Ram2Addr),
        .SramEN  (Ram2EN),
        .SramOE  (Ram2OE),
        .SramWE  (Ram2WE)
    );

    uartBridge u_uart (
        .clk       (clk),
        .rst       (rst),
        .start     (uartStart),
        .write     (uartWrite),
        .busData   (Ram1Data[7:0]),
        .data_ready(data_ready),
        .tbre      (tbre),
        .tsre      (tsre),
        .rdn       (rdn),
        .wrn       (wrn),
        .rxByte    (uartRxByte),
        .done      (uartDone)
    );

endmodule

//--- sim/memModels.sv
`timescale 1ns/1ps

//////////////////////////////////////////////////
// Asynchronous SRAM chip
//////////////////////////////////////////////////

module sramModel (
    input  logic                             clk,
    inout  wire  [memPkg::wordWidth-1:0]     Data,
    input  logic [memPkg::sramAddrWidth-1:0] Addr,
    input  logic                             EN,
    input  logic                             OE,
    input  logic                             WE
);

    // Upper address pins are tied low by the controller
    logic [memPkg::wordWidth-1:0] mem [0:65535];

    assign Data = (EN === 1'b0 && OE === 1'b0) ? mem[Addr[15:0]]
                                               : {memPkg::wordWidth{1'bz}};

    // Bus and address sampled while the write strobe is still low
    always @(posedge clk) begin
        if (EN === 1'b0 && WE === 1'b0) begin
            mem[Addr[15:0]] <= Data;
        end
    end

endmodule

//////////////////////////////////////////////////
// Serial port on the RAM 1 data bus
//////////////////////////////////////////////////

module uartModel #(
    parameter int txDelay = 3
) (
    input  logic                         clk,
    inout  wire  [7:0]                   busData,
    input  logic                         rdn,
    input  logic                         wrn,
    output logic                         data_ready,
    output logic                         tbre,
    output logic                         tsre,
    input  logic [7:0]                   rxByte,
    input  logic [3:0]                   rxDelay,
    output logic [7:0]                   txByte,
    output logic [memPkg::wordWidth-1:0] txCount
);

    int         txTimer;
    logic       txBusy;
    logic [3:0] rxTimer;

    initial begin
        data_ready = 1'b0;
        tbre       = 1'b1;
        tsre       = 1'b1;
        txByte     = 8'h00;
        txCount    = '0;
        txTimer    = 0;
        txBusy     = 1'b0;
        rxTimer    = 4'd0;
    end

    // Received byte goes out while rdn is low
    assign busData = (rdn === 1'b0) ? rxByte : 8'hzz;

    // Transmit side takes the byte on the wrn pulse
    always @(posedge clk) begin
        if (wrn === 1'b0) begin
            txByte  <= busData;
            txCount <= txCount + 1'b1;
            tbre    <= 1'b0;
            tsre    <= 1'b0;
            txTimer <= 0;
            txBusy  <= 1'b1;
        end else if (txBusy) begin
            txTimer <= txTimer + 1;
            if (txTimer == txDelay) begin
                tbre <= 1'b1;
            end
            if (txTimer == 2 * txDelay) begin
                tsre   <= 1'b1;
                txBusy <= 1'b0;
            end
        end
    end

    // data_ready rises after rxDelay cycles of rdn low
    always @(posedge clk) begin
        if (rdn === 1'b0) begin
            if (rxTimer >= rxDelay) begin
                data_ready <= 1'b1;
            end else begin
                rxTimer <= rxTimer + 1'b1;
            end
        end else begin
            rxTimer    <= 4'd0;
            data_ready <= 1'b0;
        end
    end

endmodule

//--- sim/memTop_assert.sv
`timescale 1ns/1ps

module memTop_assert (
    input logic                         clk,
    input logic                         rst,
    input logic [memPkg::wordWidth-1:0] Address,
    input logic                         MemRead,
    input logic                         MemWrite,
    input logic                         noStop,
    input logic                         Ram1OE,
    input logic                         Ram1WE,
    input logic                         rdn,
    input logic                         wrn
);

    int   failCount = 0;
    logic uartTarget;
    logic ramRequest;

    assign uartTarget = (Address == memPkg::com1Data) || (Address == memPkg::com1Command) ||
                        (Address == memPkg::com2Data) || (Address == memPkg::com2Command);
    assign ramRequest = (MemRead || MemWrite) && !uartTarget;

    // RAM 1 never reads and writes in the same cycle
    ram1Strobes: assert property (@(posedge clk) disable iff (!rst) !(!Ram1OE && !Ram1WE))
        else begin
            $error("RAM 1 OE and WE low together");
            failCount++;
        end

    uartStrobes: assert property (@(posedge clk) disable iff (!rst) !(!rdn && !wrn))
        else begin
            $error("UART rdn and wrn low together");
            failCount++;
        end

    // RAM accesses never stall the CPU
    ramNoStall: assert property (@(posedge clk) disable iff (!rst) ramRequest |-> noStop)
        else begin
            $error("noStop low during a RAM request");
            failCount++;
        end

endmodule

//--- sim/memTb.sv
`timescale 1ns/1ps

module memTb;

    localparam logic [15:0] ram1Salt     = 16'h3C5A;
    localparam logic [15:0] ram2Salt     = 16'hA1E7;
    localparam int          stallLimit   = 8;
    localparam int          releaseLimit = 40;

    logic                             clk;
    logic                             rst;
    logic [memPkg::wordWidth-1:0]     pc;
    logic [memPkg::wordWidth-1:0]     Address;
    logic [memPkg::wordWidth-1:0]     WriteData;
    logic                             MemRead;
    logic                             MemWrite;
    logic [memPkg::wordWidth-1:0]     ReadData;
    logic [memPkg::wordWidth-1:0]     Instruct;
    logic                             MemConflict;
    logic                             noStop;
    wire  [memPkg::wordWidth-1:0]     Ram1Data;
    wire  [memPkg::wordWidth-1:0]     Ram2Data;
    logic [memPkg::sramAddrWidth-1:0] Ram1Addr;
    logic [memPkg::sramAddrWidth-1:0] Ram2Addr;
    logic                             Ram1EN;
    logic                             Ram1OE;
    logic                             Ram1WE;
    logic                             Ram2EN;
    logic                             Ram2OE;
    logic                             Ram2WE;
    logic                             rdn;
    logic                             wrn;
    logic                             data_ready;
    logic                             tbre;
    logic                             tsre;
    logic [7:0]                       rxByteVal;
    logic [3:0]                       rxDelayVal;
    logic [7:0]                       txByte;
    logic [memPkg::wordWidth-1:0]     txCount;
    integer                           seed;
    int                               valueErrors;
    int                               protocolErrors;

    memTop #(
        .ram1Upper(16'h8000)
    ) u_dut (
        .clk(clk), .rst(rst), .pc(pc), .Address(Address), .WriteData(WriteData),
        .MemRead(MemRead), .MemWrite(MemWrite), .ReadData(ReadData), .Instruct(Instruct),
        .MemConflict(MemConflict), .noStop(noStop),
        .Ram1Data(Ram1Data), .Ram1Addr(Ram1Addr), .Ram1EN(Ram1EN), .Ram1OE(Ram1OE),
        .Ram1WE(Ram1WE), .Ram2Data(Ram2Data), .Ram2Addr(Ram2Addr), .Ram2EN(Ram2EN),
        .Ram2OE(Ram2OE), .Ram2WE(Ram2WE), .rdn(rdn), .wrn(wrn),
        .data_ready(data_ready), .tbre(tbre), .tsre(tsre)
    );

    sramModel ram1Model (
        .clk(clk), .Data(Ram1Data), .Addr(Ram1Addr), .EN(Ram1EN), .OE(Ram1OE), .WE(Ram1WE)
    );

    sramModel ram2Model (
        .clk(clk), .Data(Ram2Data), .Addr(Ram2Addr), .EN(Ram2EN), .OE(Ram2OE), .WE(Ram2WE)
    );

    uartModel serialModel (
        .clk(clk), .busData(Ram1Data[7:0]), .rdn(rdn), .wrn(wrn), .data_ready(data_ready),
        .tbre(tbre), .tsre(tsre), .rxByte(rxByteVal), .rxDelay(rxDelayVal),
        .txByte(txByte), .txCount(txCount)
    );

    bind memTop memTop_assert u_assert (
        .clk(clk), .rst(rst), .Address(Address), .MemRead(MemRead), .MemWrite(MemWrite),
        .noStop(noStop), .Ram1OE(Ram1OE), .Ram1WE(Ram1WE), .rdn(rdn), .wrn(wrn)
    );

    always #50 clk = ~clk;

    // Preload pattern that depends on every address bit
    function automatic logic [15:0] fillWord(input logic [15:0] addr, input logic [15:0] salt);
        return {addr[7:0], addr[15:8]} ^ salt;
    endfunction

    task automatic preloadMemories();
        int i;
        for (i = 0; i < 65536; i++) begin
            ram1Model.mem[i] = fillWord(i[15:0], ram1Salt);
            ram2Model.mem[i] = fillWord(i[15:0], ram2Salt);
        end
    endtask

    //////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////

    task automatic checkWord(input string name, input logic [memPkg::wordWidth-1:0] exp,
                             input logic [memPkg::wordWidth-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, got %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkPinAddr(input string name,
                                input logic [memPkg::sramAddrWidth-1:0] exp,
                                input logic [memPkg::sramAddrWidth-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, got %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkByte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, got %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, got %h", name, exp, act);
            valueErrors++;
        end
    endtask

    //////////////////////////////////////////////////
    // CPU side drivers
    //////////////////////////////////////////////////

    task automatic driveRequest(input logic [15:0] pcVal, input logic [15:0] addr,
                                input logic [15:0] wdata, input logic rd, input logic wr);
        @(posedge clk);
        pc        <= pcVal;
        Address   <= addr;
        WriteData <= wdata;
        MemRead   <= rd;
        MemWrite  <= wr;
    endtask

    // Four cycles always cover a RAM access and a fetch
    task automatic settleRam();
        repeat (4) @(posedge clk);
        @(negedge clk);
        checkBit("noStop", 1'b1, noStop);
    endtask

    // Serial access held until noStop rises again
    task automatic runUart(input logic [15:0] addr, input logic [15:0] wdata, input logic wr);
        int   cycles;
        logic stalled;
        logic released;
        logic sawEvent;
        stalled  = 1'b0;
        released = 1'b0;
        sawEvent = 1'b0;
        driveRequest(pc, addr, wdata, !wr, wr);
        for (cycles = 0; cycles < stallLimit && !stalled; cycles++) begin
            @(negedge clk);
            stalled = !noStop;
        end
        if (!stalled) begin
            $display("ERROR: noStop never went low for the UART access at %h", addr);
            protocolErrors++;
        end else begin
            for (cycles = 0; cycles < releaseLimit && !released; cycles++) begin
                @(negedge clk);
                if (wr ? tsre : data_ready) begin
                    sawEvent = 1'b1;
                end
                released = noStop;
            end
            if (!released) begin
                $display("ERROR: timed out waiting for noStop after the UART access");
                protocolErrors++;
            end else if (!sawEvent) begin
                $display("ERROR: noStop rose before the serial handshake finished");
                protocolErrors++;
            end
        end
        driveRequest(pc, 16'h0000, 16'h0000, 1'b0, 1'b0);
        @(negedge clk);
    endtask

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic testReset();
        @(negedge clk);
        checkBit("Ram1EN", 1'b1, Ram1EN);
        checkBit("Ram1OE", 1'b1, Ram1OE);
        checkBit("Ram1WE", 1'b1, Ram1WE);
        checkBit("Ram2EN", 1'b1, Ram2EN);
        checkBit("Ram2OE", 1'b1, Ram2OE);
        checkBit("Ram2WE", 1'b1, Ram2WE);
        checkBit("rdn", 1'b1, rdn);
        checkBit("wrn", 1'b1, wrn);
        checkBit("noStop", 1'b1, noStop);
        checkBit("MemConflict", 1'b0, MemConflict);
        checkWord("Instruct", 16'h0000, Instruct);
        checkWord("ReadData", 16'h0000, ReadData);
    endtask

    task automatic testFetch();
        int          i;
        logic [15:0] pcVal;
        for (i = 0; i < 4; i++) begin
            pcVal = 16'h0003 + i * 16'h1F31;
            driveRequest(pcVal, 16'h0000, 16'h0000, 1'b0, 1'b0);
            settleRam();
            checkWord("Instruct", fillWord(pcVal, ram1Salt), Instruct);
            checkBit("MemConflict", 1'b0, MemConflict);
            checkPinAddr("Ram1Addr", {2'b00, pcVal}, Ram1Addr);
        end
    endtask

    task automatic testRam2();
        int          i;
        logic [15:0] addr;
        logic [15:0] data;
        logic [15:0] pcVal;
        for (i = 0; i < 5; i++) begin
            addr  = 16'h8000 + i * 16'h1357;
            data  = $random(seed);
            pcVal = 16'h0100 + i;
            driveRequest(pcVal, addr, data, 1'b0, 1'b1);
            settleRam();
            checkWord("Instruct", fillWord(pcVal, ram1Salt), Instruct);
            checkPinAddr("Ram2Addr", {2'b00, addr}, Ram2Addr);
            driveRequest(pcVal, addr, 16'h0000, 1'b1, 1'b0);
            settleRam();
            checkWord("ReadData", data, ReadData);
            checkWord("Instruct", fillWord(pcVal, ram1Salt), Instruct);
            checkBit("MemConflict", 1'b0, MemConflict);
        end
    endtask

    task automatic testRam1();
        int          i;
        logic [15:0] addr;
        logic [15:0] data;
        for (i = 0; i < 2; i++) begin
            addr = (i == 0) ? 16'h1234 : 16'h7FFF;
            data = $random(seed);
            driveRequest(16'h0200, addr, data, 1'b0, 1'b1);
            settleRam();
            checkBit("MemConflict", 1'b1, MemConflict);
            checkWord("Instruct", memPkg::nopInstr, Instruct);
            checkWord("ram1Model.mem", data, ram1Model.mem[addr]);
            checkPinAddr("Ram1Addr", {2'b00, addr}, Ram1Addr);
            driveRequest(16'h0200, addr, 16'h0000, 1'b1, 1'b0);
            settleRam();
            checkWord("ReadData", data, ReadData);
            checkBit("MemConflict", 1'b1, MemConflict);
            checkWord("Instruct", memPkg::nopInstr, Instruct);
        end
    endtask

    task automatic testUartWrite();
        logic [15:0] data;
        logic [15:0] countBefore;
        data        = $random(seed);
        countBefore = txCount;
        runUart(memPkg::com1Data, data, 1'b1);
        checkByte("txByte", data[7:0], txByte);
        checkWord("txCount", countBefore + 16'd1, txCount);
    endtask

    task automatic testUartRead();
        int i;
        for (i = 0; i < 3; i++) begin
            rxByteVal  = $random(seed);
            rxDelayVal = ({$random(seed)} % 8) + 1;
            runUart(memPkg::com1Data, 16'h0000, 1'b0);
            checkWord("ReadData", {8'h00, rxByteVal}, ReadData);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b0;
        pc             = '0;
        Address        = '0;
        WriteData      = '0;
        MemRead        = 1'b0;
        MemWrite       = 1'b0;
        rxByteVal      = 8'h00;
        rxDelayVal     = 4'd1;
        seed           = 32'hdcfd2639;
        valueErrors    = 0;
        protocolErrors = 0;
        preloadMemories();
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        testReset();
        testFetch();
        testRam2();
        testRam1();
        testUartWrite();
        testUartRead();
        $display("Errors: %0d value, %0d protocol, %0d assertion",
                 valueErrors, protocolErrors, u_dut.u_assert.failCount);
        if (valueErrors == 0 && protocolErrors == 0 && u_dut.u_assert.failCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
verilog/memPkg.sv
verilog/sramPort.sv
verilog/uartBridge.sv
verilog/memoryModule.sv
verilog/memTop.sv
sim/memModels.sv
sim/memTop_assert.sv
sim/memTb.sv

//--- Bender.yml
package:
  name: memtop

sources:
  - files:
      - verilog/memPkg.sv
      - verilog/sramPort.sv
      - verilog/uartBridge.sv
      - verilog/memoryModule.sv
      - verilog/memTop.sv
  - target: simulation
    files:
      - sim/memModels.sv
      - sim/memTop_assert.sv
      - sim/memTb.sv
